// ==== src.f ====
+incdir+include
source/dcache_pkg.sv
source/dcache_tag_array.sv
source/dcache_data_array.sv
source/dcache_store_merge.sv
source/dcache_ctrl.sv
source/dcache_top.sv
verification/dcache_mem_model.sv
verification/dcache_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := dcache_tb
RTL_TOP    := dcache_top
FILELIST   := src.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing -Wall --timescale 1ns/1ps
PASS_MSG   := TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int SEED_INIT      = 6105;
    localparam int N_TESTS        = 7;
    localparam int N_RANDOM       = 60;
    localparam int NUM_OPS        = N_RANDOM + 30;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 64;
    localparam int SHADOW_BYTES   = 16384;

    logic  clk;
    logic  rst;
    logic  valid;
    addr_t addr;
    strb_t wstrb;
    word_t wdata;
    logic  data_ok;
    word_t rdata;
    logic  cacop;
    logic  cacop_mode;
    addr_t cacop_addr;
    logic  cacop_ack;
    logic  mem_req;
    logic  mem_we;
    addr_t mem_addr;
    line_t mem_wdata;
    logic  mem_ready;
    logic  mem_rvalid;
    logic  mem_bvalid;
    line_t mem_rdata;

    // reference state kept by the testbench
    logic [7:0]    shadow [SHADOW_BYTES];
    logic [1023:0] stored_line;
    word_t         exp_rdata;
    logic          load_op;
    logic          expect_hit;
    logic          started;
    int            seed;
    int            err_count;
    int            tests_run;
    int            tests_failed;
    int            wb_count;
    int            rd_count;

    dcache_top dcache_top_i (
        .clk(clk), .rst(rst),
        .valid_i(valid), .addr_i(addr), .wstrb_i(wstrb), .wdata_i(wdata),
        .data_ok_o(data_ok), .rdata_o(rdata),
        .cacop_i(cacop), .cacop_mode_i(cacop_mode), .cacop_addr_i(cacop_addr),
        .cacop_ack_o(cacop_ack),
        .mem_req_o(mem_req), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
        .mem_wdata_o(mem_wdata), .mem_ready_i(mem_ready), .mem_rvalid_i(mem_rvalid),
        .mem_bvalid_i(mem_bvalid), .mem_rdata_i(mem_rdata)
    );

    dcache_mem_model #(.SEED(SEED_INIT)) u_mem (
        .clk(clk), .rst(rst),
        .req_i(mem_req), .we_i(mem_we), .addr_i(mem_addr), .wdata_i(mem_wdata),
        .ready_o(mem_ready), .rvalid_o(mem_rvalid), .bvalid_o(mem_bvalid),
        .rdata_o(mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the cache stopped answering",
                 TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    task automatic report_error(input string msg);
        err_count++;
        $display("[ERROR] %0t %s", $time, msg);
    endtask

    function automatic word_t pattern_word(input addr_t a);
        return {a[31:2], 2'b00} ^ 32'hA5A5_5A5A;
    endfunction

    function automatic word_t shadow_word(input addr_t a);
        return {shadow[{a[13:2], 2'd3}], shadow[{a[13:2], 2'd2}],
                shadow[{a[13:2], 2'd1}], shadow[{a[13:2], 2'd0}]};
    endfunction

    function automatic line_t shadow_line(input addr_t a);
        line_t l;
        for (int b = 0; b < 16; b++) begin
            l[b*8 +: 8] = shadow[{a[13:4], 4'(b)}];
        end
        return l;
    endfunction

    function automatic addr_t make_addr(input int t, input logic [7:0] idx, input int w);
        return {20'(t), idx, 2'(w), 2'b00};
    endfunction

    function automatic addr_t random_addr();
        int t;
        int x;
        int w;
        t = int'($unsigned($random(seed)) % 3);
        x = int'($unsigned($random(seed)) % 3);
        w = int'($unsigned($random(seed)) % 4);
        // three tags over three sets make the ways run out often
        return make_addr(t, 8'h10 + 8'(x), w);
    endfunction

    // shadow of one line goes back to the memory start pattern
    task automatic restore_line(input addr_t a);
        word_t pw;
        for (int w = 0; w < 4; w++) begin
            pw = pattern_word({a[31:4], 2'(w), 2'b00});
            for (int b = 0; b < 4; b++) begin
                shadow[{a[13:4], 2'(w), 2'(b)}] <= pw[b*8 +: 8];
            end
        end
    endtask

    task automatic wait_data_ok();
        do begin
            @(posedge clk);
        end while (data_ok !== 1'b1);
    endtask

    task automatic wait_ack();
        do begin
            @(posedge clk);
        end while (cacop_ack !== 1'b1);
    endtask

    task automatic load_word(input addr_t a, input logic hit);
        @(posedge clk);
        valid      <= 1'b1;
        addr       <= a;
        wstrb      <= '0;
        exp_rdata  <= shadow_word(a);
        load_op    <= 1'b1;
        expect_hit <= hit;
        started    <= 1'b1;
        @(posedge clk);
        valid <= 1'b0;
        wait_data_ok();
        load_op    <= 1'b0;
        expect_hit <= 1'b0;
    endtask

    task automatic store_word(input addr_t a, input strb_t s, input word_t d, input logic hit);
        @(posedge clk);
        valid      <= 1'b1;
        addr       <= a;
        wstrb      <= s;
        wdata      <= d;
        expect_hit <= hit;
        started    <= 1'b1;
        stored_line[a[13:4]] <= 1'b1;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                shadow[{a[13:2], 2'(b)}] <= d[b*8 +: 8];
            end
        end
        @(posedge clk);
        valid <= 1'b0;
        wait_data_ok();
        expect_hit <= 1'b0;
    endtask

    task automatic cache_op(input logic mode, input logic [7:0] idx, input logic way);
        @(posedge clk);
        cacop      <= 1'b1;
        cacop_mode <= mode;
        cacop_addr <= {20'd0, idx, 3'd0, way};
        started    <= 1'b1;
        @(posedge clk);
        cacop <= 1'b0;
        wait_ack();
    endtask

    task automatic random_traffic();
        addr_t a;
        int    kind;
        int    lane;
        strb_t s;
        for (int i = 0; i < N_RANDOM; i++) begin
            a    = random_addr();
            kind = int'($unsigned($random(seed)) % 4);
            lane = int'($unsigned($random(seed)) % 4);
            case (kind)
                0:       s = '0;
                1:       s = strb_t'(4'b0001 << lane);
                2:       s = lane[0] ? 4'b1100 : 4'b0011;
                default: s = 4'b1111;
            endcase
            if (s == '0) begin
                load_word(a, 1'b0);
            end else begin
                store_word(a, s, $random(seed), 1'b0);
            end
        end
    endtask

    task automatic close_test(input string name, input int errs_before);
        tests_run++;
        if (err_count != errs_before) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, err_count - errs_before);
        end else begin
            $display("test %s: passed", name);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            wb_count <= 0;
            rd_count <= 0;
        end else if (mem_req) begin
            if (mem_we) begin
                wb_count <= wb_count + 1;
            end else begin
                rd_count <= rd_count + 1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        !started |-> !(data_ok || cacop_ack || mem_req))
        else report_error("cache output active before the first request");

    assert property (@(posedge clk) disable iff (rst)
        data_ok && load_op |-> rdata == exp_rdata)
        else report_error($sformatf("load returned %h, expected %h",
                                    $sampled(rdata), $sampled(exp_rdata)));

    assert property (@(posedge clk) disable iff (rst)
        $past(valid && expect_hit, 2) |-> data_ok)
        else report_error("hit did not answer one cycle after capture");

    assert property (@(posedge clk) disable iff (rst)
        !(expect_hit && mem_req))
        else report_error("memory request issued on a hit");

    assert property (@(posedge clk) disable iff (rst)
        mem_req |-> mem_ready && mem_addr[3:0] == 4'd0)
        else report_error("memory request without ready or not line aligned");

    assert property (@(posedge clk) disable iff (rst)
        mem_req && mem_we |-> mem_wdata == shadow_line(mem_addr))
        else report_error($sformatf("write-back of %h carries wrong data",
                                    $sampled(mem_addr)));

    assert property (@(posedge clk) disable iff (rst)
        mem_req && mem_we |-> stored_line[mem_addr[13:4]])
        else report_error($sformatf("write-back of never stored line %h",
                                    $sampled(mem_addr)));

    initial begin
        int errs;
        int wb_before;
        int rd_before;
        rst          = 1'b1;
        valid        = 1'b0;
        addr         = '0;
        wstrb        = '0;
        wdata        = '0;
        cacop        = 1'b0;
        cacop_mode   = 1'b0;
        cacop_addr   = '0;
        exp_rdata    = '0;
        load_op      = 1'b0;
        expect_hit   = 1'b0;
        started      = 1'b0;
        stored_line  = '0;
        seed         = SEED_INIT;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int l = 0; l < 1024; l++) begin
            restore_line(addr_t'(l) << 4);
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        errs = err_count;
        repeat (8) @(posedge clk);
        close_test("reset_quiet", errs);

        errs = err_count;
        load_word(make_addr(0, 8'h50, 1), 1'b0);
        load_word(make_addr(0, 8'h50, 1), 1'b1);
        load_word(make_addr(0, 8'h50, 3), 1'b1);
        close_test("load_repeat", errs);

        errs = err_count;
        store_word(make_addr(1, 8'h30, 0), 4'b0010, 32'h1122_3344, 1'b0);
        store_word(make_addr(1, 8'h30, 0), 4'b1100, 32'hCAFE_0000, 1'b1);
        store_word(make_addr(1, 8'h30, 2), 4'b1111, 32'h0BAD_F00D, 1'b1);
        store_word(make_addr(2, 8'h31, 1), 4'b0011, 32'h0000_BEEF, 1'b0);
        load_word(make_addr(1, 8'h30, 0), 1'b1);
        load_word(make_addr(1, 8'h30, 2), 1'b1);
        load_word(make_addr(2, 8'h31, 1), 1'b1);
        close_test("store_merge", errs);

        // three tags on one set force dirty evictions
        errs = err_count;
        for (int t = 0; t < 3; t++) begin
            store_word(make_addr(t, 8'h20, t), 4'b1111, $random(seed), 1'b0);
        end
        for (int t = 0; t < 3; t++) begin
            load_word(make_addr(t, 8'h20, t), 1'b0);
            load_word(make_addr(t, 8'h21, 0), 1'b0);
        end
        close_test("conflict_writeback", errs);

        errs = err_count;
        store_word(make_addr(3, 8'h40, 2), 4'b1111, 32'h5EED_1234, 1'b0);
        wb_before = wb_count;
        cache_op(1'b1, 8'h40, 1'b0);
        cache_op(1'b1, 8'h40, 1'b1);
        assert (wb_count == wb_before + 1)
            else report_error("mode 1 did not write the dirty line back once");
        rd_before = rd_count;
        load_word(make_addr(3, 8'h40, 2), 1'b0);
        assert (rd_count > rd_before)
            else report_error("load after mode 1 did not read memory");
        close_test("maint_writeback", errs);

        errs = err_count;
        store_word(make_addr(3, 8'h41, 1), 4'b1111, 32'hDEAD_0001, 1'b0);
        wb_before = wb_count;
        cache_op(1'b0, 8'h41, 1'b0);
        cache_op(1'b0, 8'h41, 1'b1);
        assert (wb_count == wb_before)
            else report_error("mode 0 wrote a line to memory");
        // memory still holds the start pattern because the dirty data was dropped
        restore_line(make_addr(3, 8'h41, 0));
        load_word(make_addr(3, 8'h41, 1), 1'b0);
        close_test("maint_invalidate", errs);

        errs = err_count;
        random_traffic();
        close_test("random_traffic", errs);

        $display("tests %0d of %0d, failed %0d, errors %0d",
                 tests_run, N_TESTS, tests_failed, err_count);
        if (err_count == 0 && tests_run == N_TESTS) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/dcache_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_model #(
    parameter int SEED = 1
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_i,
    input  logic              we_i,
    input  dcache_pkg::addr_t addr_i,
    input  dcache_pkg::line_t wdata_i,
    output logic              ready_o,
    output logic              rvalid_o,
    output logic              bvalid_o,
    output dcache_pkg::line_t rdata_o
);
    import dcache_pkg::*;

    localparam int DEPTH = 1024;

    line_t       mem [DEPTH];
    int          seed;
    int unsigned delay_q;

    initial begin
        seed = SEED;
        ready_o  <= 1'b0;
        rvalid_o <= 1'b0;
        bvalid_o <= 1'b0;
        rdata_o  <= '0;
    end

    always @(posedge clk) begin
        if (rst) begin
            ready_o  <= 1'b0;
            rvalid_o <= 1'b0;
            bvalid_o <= 1'b0;
            rdata_o  <= '0;
            delay_q  <= 0;
            // every word starts as its own address xor a fixed pattern
            for (int i = 0; i < DEPTH; i++) begin
                for (int w = 0; w < 4; w++) begin
                    mem[i][w*32 +: 32] <= ((32'(i) << 4) + 32'(w * 4)) ^ 32'hA5A5_5A5A;
                end
            end
        end else begin
            rvalid_o <= 1'b0;
            bvalid_o <= 1'b0;
            if (req_i && ready_o) begin
                ready_o <= 1'b0;
                delay_q <= $unsigned($random(seed)) % 4;
                if (we_i) begin
                    mem[addr_i[13:4]] <= wdata_i;
                    bvalid_o          <= 1'b1;
                end else begin
                    rdata_o  <= mem[addr_i[13:4]];
                    rvalid_o <= 1'b1;
                end
            end else if (!ready_o) begin
                // ready comes back after 0 to 3 idle cycles
                if (delay_q == 0) begin
                    ready_o <= 1'b1;
                end else begin
                    delay_q <= delay_q - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              valid_i,
    input  dcache_pkg::addr_t addr_i,
    input  dcache_pkg::strb_t wstrb_i,
    input  dcache_pkg::word_t wdata_i,
    output logic              data_ok_o,
    output dcache_pkg::word_t rdata_o,
    input  logic              cacop_i,
    input  logic              cacop_mode_i,
    input  dcache_pkg::addr_t cacop_addr_i,
    output logic              cacop_ack_o,
    output logic              mem_req_o,
    output logic              mem_we_o,
    output dcache_pkg::addr_t mem_addr_o,
    output dcache_pkg::line_t mem_wdata_o,
    input  logic              mem_ready_i,
    input  logic              mem_rvalid_i,
    input  logic              mem_bvalid_i,
    input  dcache_pkg::line_t mem_rdata_i
);

    dcache_pkg::index_t   arr_index;
    dcache_pkg::way_vec_t hit_way;
    dcache_pkg::tag_t     victim_tag;
    logic                 victim_dirty;
    dcache_pkg::line_t    rline;
    dcache_pkg::way_vec_t tag_we;
    dcache_pkg::tag_t     tag_wdata;
    logic                 valid_wdata;
    logic                 dirty_wdata;
    dcache_pkg::way_vec_t data_be;
    dcache_pkg::line_be_t line_be;
    logic                 fill_sel;
    dcache_pkg::addr_t    req_offset;
    dcache_pkg::strb_t    req_wstrb;
    dcache_pkg::word_t    req_wdata;
    dcache_pkg::way_t     victim_way;
    dcache_pkg::line_t    wline;

    dcache_ctrl u_ctrl (
        .clk(clk), .rst(rst),
        .valid_i(valid_i), .addr_i(addr_i), .wstrb_i(wstrb_i), .wdata_i(wdata_i),
        .cacop_i(cacop_i), .cacop_mode_i(cacop_mode_i), .cacop_addr_i(cacop_addr_i),
        .data_ok_o(data_ok_o), .cacop_ack_o(cacop_ack_o),
        .mem_req_o(mem_req_o), .mem_we_o(mem_we_o),
        .mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o),
        .mem_ready_i(mem_ready_i), .mem_rvalid_i(mem_rvalid_i), .mem_bvalid_i(mem_bvalid_i),
        .hit_way_i(hit_way), .victim_tag_i(victim_tag),
        .victim_dirty_i(victim_dirty), .victim_line_i(rline),
        .arr_index_o(arr_index), .tag_we_o(tag_we), .tag_wdata_o(tag_wdata),
        .valid_wdata_o(valid_wdata), .dirty_wdata_o(dirty_wdata),
        .data_be_o(data_be), .line_be_o(line_be), .fill_sel_o(fill_sel),
        .req_offset_o(req_offset), .req_wstrb_o(req_wstrb), .req_wdata_o(req_wdata),
        .victim_way_o(victim_way)
    );

    // lookup tag and write tag are both the captured request tag
    dcache_tag_array u_tag_array (
        .clk(clk), .rst(rst),
        .index_i(arr_index), .tag_i(tag_wdata),
        .we_i(tag_we), .wtag_i(tag_wdata),
        .wvalid_i(valid_wdata), .wdirty_i(dirty_wdata),
        .victim_way_i(victim_way),
        .hit_way_o(hit_way), .victim_tag_o(victim_tag), .victim_dirty_o(victim_dirty)
    );

    dcache_data_array u_data_array (
        .clk(clk),
        .index_i(arr_index), .way_we_i(data_be), .be_i(line_be),
        .wline_i(wline), .rd_way_i(victim_way), .rline_o(rline)
    );

    dcache_store_merge u_store_merge (
        .offset_i(req_offset), .wstrb_i(req_wstrb), .wdata_i(req_wdata),
        .fill_sel_i(fill_sel), .fill_line_i(mem_rdata_i), .hit_line_i(rline),
        .wline_o(wline), .rdata_o(rdata_o)
    );

endmodule

`default_nettype wire

// ==== source/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  valid_i,
    input  dcache_pkg::addr_t     addr_i,
    input  dcache_pkg::strb_t     wstrb_i,
    input  dcache_pkg::word_t     wdata_i,
    input  logic                  cacop_i,
    input  logic                  cacop_mode_i,
    input  dcache_pkg::addr_t     cacop_addr_i,
    output logic                  data_ok_o,
    output logic                  cacop_ack_o,
    output logic                  mem_req_o,
    output logic                  mem_we_o,
    output dcache_pkg::addr_t     mem_addr_o,
    output dcache_pkg::line_t     mem_wdata_o,
    input  logic                  mem_ready_i,
    input  logic                  mem_rvalid_i,
    input  logic                  mem_bvalid_i,
    input  dcache_pkg::way_vec_t  hit_way_i,
    input  dcache_pkg::tag_t      victim_tag_i,
    input  logic                  victim_dirty_i,
    input  dcache_pkg::line_t     victim_line_i,
    output dcache_pkg::index_t    arr_index_o,
    output dcache_pkg::way_vec_t  tag_we_o,
    output dcache_pkg::tag_t      tag_wdata_o,
    output logic                  valid_wdata_o,
    output logic                  dirty_wdata_o,
    output dcache_pkg::way_vec_t  data_be_o,
    output dcache_pkg::line_be_t  line_be_o,
    output logic                  fill_sel_o,
    output dcache_pkg::addr_t     req_offset_o,
    output dcache_pkg::strb_t     req_wstrb_o,
    output dcache_pkg::word_t     req_wdata_o,
    output dcache_pkg::way_t      victim_way_o
);
    import dcache_pkg::*;

    localparam int BYTE_SEL_W = $clog2(`DC_STRB_W);
    localparam int WORD_SEL_W = `DC_OFFSET_W - BYTE_SEL_W;

    dc_state_e state_q;
    dc_state_e state_d;
    addr_t     req_addr_q;
    strb_t     wstrb_q;
    word_t     wdata_q;
    logic      mode_q;
    way_t      victim_q;
    logic      data_ok_q;
    logic      ack_q;
    logic [15:0] lfsr_q;

    index_t    req_index;
    tag_t      req_tag;
    logic [WORD_SEL_W-1:0] req_word;
    logic      is_store;
    logic      hit_any;
    way_t      hit_idx;
    way_vec_t  victim_vec;
    addr_t     victim_addr;
    addr_t     fill_addr;
    logic      maint_wb;

    assign req_index   = req_addr_q[`DC_OFFSET_W +: `DC_INDEX_W];
    assign req_tag     = req_addr_q[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign req_word    = req_addr_q[BYTE_SEL_W +: WORD_SEL_W];
    assign is_store    = |wstrb_q;
    assign hit_any     = |hit_way_i;
    assign victim_vec  = way_vec_t'(1) << victim_q;
    assign victim_addr = {victim_tag_i, req_index, {`DC_OFFSET_W{1'b0}}};
    assign fill_addr   = {req_tag, req_index, {`DC_OFFSET_W{1'b0}}};
    // mode 1 on a dirty line goes out to memory first
    assign maint_wb    = mode_q && victim_dirty_i;

    always_comb begin
        hit_idx = '0;
        for (int w = 0; w < `DC_NWAY; w++) begin
            if (hit_way_i[w]) begin
                hit_idx = way_t'(w);
            end
        end
    end

    // hit way while looking up, the latched victim once a miss is in progress
    always_comb begin
        case (state_q)
            IDLE, LOOKUP: victim_way_o = hit_any ? hit_idx : way_t'(lfsr_q[0]);
            default:      victim_way_o = victim_q;
        endcase
    end

    always_comb begin
        state_d       = state_q;
        tag_we_o      = '0;
        valid_wdata_o = 1'b0;
        dirty_wdata_o = 1'b0;
        data_be_o     = '0;
        line_be_o     = '0;
        fill_sel_o    = 1'b0;
        mem_req_o     = 1'b0;
        mem_we_o      = 1'b0;
        mem_addr_o    = fill_addr;
        case (state_q)
            IDLE: begin
                if (cacop_i) begin
                    state_d = MAINT_CHECK;
                end else if (valid_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit_any) begin
                    if (is_store) begin
                        tag_we_o      = hit_way_i;
                        valid_wdata_o = 1'b1;
                        dirty_wdata_o = 1'b1;
                        data_be_o     = hit_way_i;
                        line_be_o     = line_be_t'(wstrb_q) << (req_word * `DC_STRB_W);
                    end
                    state_d = IDLE;
                end else begin
                    state_d = victim_dirty_i ? WB_REQ : FILL_REQ;
                end
            end
            WB_REQ, MAINT_WB_REQ: begin
                mem_addr_o = victim_addr;
                if (mem_ready_i) begin
                    mem_req_o = 1'b1;
                    mem_we_o  = 1'b1;
                    state_d   = (state_q == WB_REQ) ? WB_WAIT : MAINT_WB_WAIT;
                end
            end
            WB_WAIT: begin
                mem_addr_o = victim_addr;
                if (mem_bvalid_i) begin
                    state_d = FILL_REQ;
                end
            end
            FILL_REQ: begin
                if (mem_ready_i) begin
                    mem_req_o = 1'b1;
                    state_d   = FILL_WAIT;
                end
            end
            FILL_WAIT: begin
                if (mem_rvalid_i) begin
                    tag_we_o      = victim_vec;
                    valid_wdata_o = 1'b1;
                    dirty_wdata_o = is_store;
                    data_be_o     = victim_vec;
                    line_be_o     = '1;
                    fill_sel_o    = 1'b1;
                    state_d       = IDLE;
                end
            end
            MAINT_CHECK: begin
                if (maint_wb) begin
                    state_d = MAINT_WB_REQ;
                end else begin
                    // valid and dirty written as zero
                    tag_we_o = victim_vec;
                    state_d  = IDLE;
                end
            end
            MAINT_WB_WAIT: begin
                mem_addr_o = victim_addr;
                if (mem_bvalid_i) begin
                    tag_we_o = victim_vec;
                    state_d  = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= IDLE;
            data_ok_q <= 1'b0;
            ack_q     <= 1'b0;
            lfsr_q    <= `DC_LFSR_SEED;
        end else begin
            state_q   <= state_d;
            data_ok_q <= (state_q == LOOKUP && hit_any) || (state_q == FILL_WAIT && mem_rvalid_i);
            ack_q     <= (state_q == MAINT_CHECK && !maint_wb) ||
                         (state_q == MAINT_WB_WAIT && mem_bvalid_i);
            // taps 16,14,13,11
            lfsr_q    <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
        end
    end

    // maintenance takes priority over a CPU request
    always_ff @(posedge clk) begin
        if (state_q == IDLE && cacop_i) begin
            req_addr_q <= cacop_addr_i;
            mode_q     <= cacop_mode_i;
            victim_q   <= cacop_addr_i[$clog2(`DC_NWAY)-1:0];
        end else if (state_q == IDLE && valid_i) begin
            req_addr_q <= addr_i;
            wstrb_q    <= wstrb_i;
            wdata_q    <= wdata_i;
        end else if (state_q == LOOKUP && !hit_any) begin
            victim_q <= way_t'(lfsr_q[0]);
        end
    end

    assign data_ok_o    = data_ok_q;
    assign cacop_ack_o  = ack_q;
    assign mem_wdata_o  = victim_line_i;
    assign arr_index_o  = req_index;
    assign tag_wdata_o  = req_tag;
    assign req_offset_o = addr_t'(req_addr_q[`DC_OFFSET_W-1:0]);
    assign req_wstrb_o  = wstrb_q;
    assign req_wdata_o  = wdata_q;

endmodule

`default_nettype wire

// ==== source/dcache_store_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache_store_merge (
    input  dcache_pkg::addr_t offset_i,
    input  dcache_pkg::strb_t wstrb_i,
    input  dcache_pkg::word_t wdata_i,
    input  logic              fill_sel_i,
    input  dcache_pkg::line_t fill_line_i,
    input  dcache_pkg::line_t hit_line_i,
    output dcache_pkg::line_t wline_o,
    output dcache_pkg::word_t rdata_o
);
    import dcache_pkg::*;

    localparam int WORDS      = `DC_LINE_W / `DC_WORD_W;
    localparam int WORD_SEL_W = $clog2(WORDS);
    localparam int BYTE_SEL_W = $clog2(`DC_STRB_W);

    logic [WORD_SEL_W-1:0] word_sel;
    word_t                 fill_word;
    word_t                 merged_word;

    assign word_sel = offset_i[BYTE_SEL_W +: WORD_SEL_W];

    always_comb begin
        fill_word   = fill_line_i[word_sel*`DC_WORD_W +: `DC_WORD_W];
        merged_word = fill_word;
        // overlay the strobed store bytes on the returned word
        for (int b = 0; b < `DC_STRB_W; b++) begin
            if (wstrb_i[b]) begin
                merged_word[b*8 +: 8] = wdata_i[b*8 +: 8];
            end
        end

        if (fill_sel_i) begin
            wline_o = fill_line_i;
            wline_o[word_sel*`DC_WORD_W +: `DC_WORD_W] = merged_word;
            rdata_o = merged_word;
        end else begin
            // byte enables of a hit store pick the lanes
            wline_o = {WORDS{wdata_i}};
            rdata_o = hit_line_i[word_sel*`DC_WORD_W +: `DC_WORD_W];
        end
    end

endmodule

`default_nettype wire

// ==== source/dcache_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache_data_array (
    input  logic                 clk,
    input  dcache_pkg::index_t   index_i,
    input  dcache_pkg::way_vec_t way_we_i,
    input  dcache_pkg::line_be_t be_i,
    input  dcache_pkg::line_t    wline_i,
    input  dcache_pkg::way_t     rd_way_i,
    output dcache_pkg::line_t    rline_o
);
    import dcache_pkg::*;

    localparam int LINE_BYTES = `DC_LINE_W / 8;

    line_t line_mem [`DC_NWAY][`DC_NSET];

    // only the enabled way and bytes are written
    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_NWAY; w++) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (way_we_i[w] && be_i[b]) begin
                    line_mem[w][index_i][b*8 +: 8] <= wline_i[b*8 +: 8];
                end
            end
        end
    end

    // rd_way is the hit way on a lookup, the victim way otherwise
    assign rline_o = line_mem[rd_way_i][index_i];

endmodule

`default_nettype wire

// ==== source/dcache_tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache_tag_array (
    input  logic                clk,
    input  logic                rst,
    input  dcache_pkg::index_t  index_i,
    input  dcache_pkg::tag_t    tag_i,
    input  dcache_pkg::way_vec_t we_i,
    input  dcache_pkg::tag_t    wtag_i,
    input  logic                wvalid_i,
    input  logic                wdirty_i,
    input  dcache_pkg::way_t    victim_way_i,
    output dcache_pkg::way_vec_t hit_way_o,
    output dcache_pkg::tag_t    victim_tag_o,
    output logic                victim_dirty_o
);
    import dcache_pkg::*;

    tag_t tag_mem [`DC_NWAY][`DC_NSET];
    logic [`DC_NSET-1:0] valid_q [`DC_NWAY];
    logic [`DC_NSET-1:0] dirty_q [`DC_NWAY];

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_NWAY; w++) begin
            if (we_i[w]) begin
                tag_mem[w][index_i] <= wtag_i;
            end
        end
    end

    // valid and dirty bits per way and set
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < `DC_NWAY; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
        end else begin
            for (int w = 0; w < `DC_NWAY; w++) begin
                if (we_i[w]) begin
                    valid_q[w][index_i] <= wvalid_i;
                    dirty_q[w][index_i] <= wdirty_i;
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < `DC_NWAY; w++) begin
            hit_way_o[w] = valid_q[w][index_i] && (tag_mem[w][index_i] == tag_i);
        end
    end

    assign victim_tag_o   = tag_mem[victim_way_i][index_i];
    assign victim_dirty_o = dirty_q[victim_way_i][index_i];

endmodule

`default_nettype wire

// ==== source/dcache_pkg.sv ====
`default_nettype none

`include "dcache_params.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0] addr_t;
    typedef logic [`DC_WORD_W-1:0] word_t;
    typedef logic [`DC_LINE_W-1:0] line_t;
    typedef logic [`DC_TAG_W-1:0] tag_t;
    typedef logic [`DC_INDEX_W-1:0] index_t;
    typedef logic [`DC_STRB_W-1:0] strb_t;
    // one enable per byte of a line
    typedef logic [`DC_LINE_W/8-1:0] line_be_t;
    typedef logic [$clog2(`DC_NWAY)-1:0] way_t;
    typedef logic [`DC_NWAY-1:0] way_vec_t;

    typedef enum logic [3:0] {
        IDLE, LOOKUP, WB_REQ, WB_WAIT, FILL_REQ, FILL_WAIT,
        MAINT_CHECK, MAINT_WB_REQ, MAINT_WB_WAIT
    } dc_state_e;

endpackage

`default_nettype wire

// ==== include/dcache_params.svh ====
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// cache geometry
`define DC_NWAY 2
`define DC_NSET 256

// widths
`define DC_ADDR_W 32
`define DC_WORD_W 32
`define DC_LINE_W 128
`define DC_OFFSET_W 4
`define DC_INDEX_W 8
`define DC_TAG_W 20
`define DC_STRB_W 4

// nonzero start value of the victim LFSR
`define DC_LFSR_SEED 16'hACE1

`endif
